/* hw/cpuPkg.sv */
// shared types for the memory side
package cpuPkg;

    parameter int addrW = 32;
    parameter int dataW = 32;
    parameter int tagW  = 4;

    // load/store opcodes
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsOp_e;

    // memory controller states
    typedef enum logic [1:0] {
        IDLE,
        INST,
        DATA
    } memState_e;

    // one data access toward the controller
    typedef struct packed {
        logic [addrW-1:0] addr;
        logic [2:0]       len;
        logic             write;
        logic [dataW-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        lsOp_e            op;
        logic [dataW-1:0] base;
        logic [dataW-1:0] storeVal;
        logic [dataW-1:0] imm;
        logic [tagW-1:0]  tag;
    } lsCmd_t;

    // data is zero for stores
    typedef struct packed {
        logic [tagW-1:0]  tag;
        logic [dataW-1:0] data;
    } lsResult_t;

    typedef struct packed {
        logic [addrW-1:0] pc;
        logic [dataW-1:0] inst;
    } fetchOut_t;

endpackage

/* hw/icache.sv */
// direct-mapped instruction cache
`timescale 1ns/1ps

module icache
    import cpuPkg::*;
#(
    parameter int icacheLines = 64
) (
    input  logic             clk_in,
    input  logic             rstN,
    input  logic             rdy_in,
    input  logic             fetchEn,
    input  logic [addrW-1:0] fetchAddr,
    input  logic             instOutEn,
    input  logic [dataW-1:0] inst,
    input  logic [addrW-1:0] instAddr,
    output logic             hit,
    output logic [dataW-1:0] cacheInst,
    output logic             memFetchEn,
    output logic [addrW-1:0] memFetchAddr
);

    localparam int idxW    = $clog2(icacheLines);
    localparam int tagBits = addrW - idxW - 2;

    logic [icacheLines-1:0] validQ;
    logic [tagBits-1:0]     tagMem  [icacheLines];
    logic [dataW-1:0]       dataMem [icacheLines];

    logic [idxW-1:0]    lookIdx;
    logic [idxW-1:0]    fillIdx;
    logic [tagBits-1:0] lookTag;
    logic               lineHit;
    logic               fillHit;

    // word address picks the line
    assign lookIdx = fetchAddr[idxW+1:2];
    assign lookTag = fetchAddr[addrW-1:idxW+2];
    assign fillIdx = instAddr[idxW+1:2];

    assign lineHit = validQ[lookIdx] && (tagMem[lookIdx] == lookTag);
    // fill returning this cycle counts as a hit
    assign fillHit = instOutEn && (instAddr == fetchAddr);

    assign hit       = fetchEn && (lineHit || fillHit);
    assign cacheInst = fillHit ? inst : dataMem[lookIdx];

    // request stays up until the line is present
    assign memFetchEn   = fetchEn && !(lineHit || fillHit);
    assign memFetchAddr = {fetchAddr[addrW-1:2], 2'b00};

    always_ff @(posedge clk_in) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (rdy_in && instOutEn) begin
            validQ[fillIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && instOutEn) begin
            tagMem[fillIdx]  <= instAddr[addrW-1:idxW+2];
            dataMem[fillIdx] <= inst;
        end
    end

endmodule

/* hw/memCtrl.sv */
// byte-serial RAM controller
`timescale 1ns/1ps

module memCtrl
    import cpuPkg::*;
(
    input  logic             clk_in,
    input  logic             rstN,
    input  logic             rdy_in,
    input  logic             memFetchEn,
    input  logic [addrW-1:0] memFetchAddr,
    output logic             instOutEn,
    output logic [dataW-1:0] inst,
    output logic [addrW-1:0] instAddr,
    input  logic             dataEn,
    input  memReq_t          dataReq,
    output logic             dataDone,
    output logic [dataW-1:0] ldData,
    input  logic [7:0]       memDin,
    output logic [7:0]       memDout,
    output logic [addrW-1:0] memA,
    output logic             memWr
);

    memState_e state;
    logic [2:0] cnt;
    logic       dataPend;
    logic       instDoneQ;
    logic       dataDoneQ;

    memReq_t          pendReq;
    logic [addrW-1:0] baseQ;
    logic [2:0]       lenQ;
    logic             writeQ;
    logic [dataW-1:0] wBuf;
    logic [dataW-1:0] rdBuf;

    memReq_t          curReq;
    logic             dataAvail;
    logic [1:0]       byteIdx;
    logic [dataW-1:0] gathered;

    // data side wins in IDLE, a parked request first
    assign dataAvail = dataPend || dataEn;
    assign curReq    = dataPend ? pendReq : dataReq;

    // byte on memDin belongs to the address sent last cycle
    assign byteIdx = 2'(cnt - 3'd1);

    always_comb begin
        gathered = rdBuf;
        gathered[byteIdx*8 +: 8] = memDin;
    end

    always_comb begin
        memA    = baseQ + addrW'(cnt);
        memDout = wBuf[7:0];
        memWr   = 1'b0;
        case (state)
            IDLE: begin
                // first byte goes out in the accept cycle
                if (dataAvail) begin
                    memA    = curReq.addr;
                    memDout = curReq.wdata[7:0];
                    memWr   = rdy_in && curReq.write;
                end else begin
                    memA = memFetchAddr;
                end
            end
            DATA: memWr = rdy_in && writeQ;
            default: ;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rstN) begin
            state     <= IDLE;
            cnt       <= '0;
            dataPend  <= 1'b0;
            instDoneQ <= 1'b0;
            dataDoneQ <= 1'b0;
        end else if (rdy_in) begin
            instDoneQ <= 1'b0;
            dataDoneQ <= 1'b0;
            case (state)
                IDLE: begin
                    cnt <= 3'd1;
                    if (dataAvail) begin
                        dataPend <= 1'b0;
                        // single byte store is finished already
                        if (curReq.write && curReq.len == 3'd1) begin
                            dataDoneQ <= 1'b1;
                        end else begin
                            state <= DATA;
                        end
                    end else if (memFetchEn) begin
                        state <= INST;
                    end
                end
                INST: begin
                    if (cnt == 3'd4) begin
                        state     <= IDLE;
                        instDoneQ <= 1'b1;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                DATA: begin
                    if (writeQ ? (cnt == lenQ - 3'd1) : (cnt == lenQ)) begin
                        state     <= IDLE;
                        dataDoneQ <= 1'b1;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: state <= IDLE;
            endcase
            // park a data request that arrives mid-transfer
            if (dataEn && state != IDLE) begin
                dataPend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (dataEn && state != IDLE) begin
                pendReq <= dataReq;
            end
            if (state == IDLE) begin
                rdBuf <= '0;
                if (dataAvail) begin
                    baseQ  <= curReq.addr;
                    lenQ   <= curReq.len;
                    writeQ <= curReq.write;
                    wBuf   <= curReq.wdata >> 8;
                end else begin
                    baseQ  <= memFetchAddr;
                    lenQ   <= 3'd4;
                    writeQ <= 1'b0;
                end
            end else begin
                wBuf <= wBuf >> 8;
                if (!writeQ) begin
                    rdBuf <= gathered;
                end
            end
        end
    end

    // strobes stay quiet while paused
    assign instOutEn = instDoneQ && rdy_in;
    assign dataDone  = dataDoneQ && rdy_in;
    assign inst      = rdBuf;
    assign ldData    = rdBuf;
    assign instAddr  = baseQ;

endmodule

/* hw/fetch.sv */
// instruction fetcher
`timescale 1ns/1ps

module fetch
    import cpuPkg::*;
(
    input  logic             clk_in,
    input  logic             rstN,
    input  logic             rdy_in,
    input  logic             stall,
    input  logic             jumpEn,
    input  logic [addrW-1:0] jumpAddr,
    input  logic             hit,
    input  logic [dataW-1:0] cacheInst,
    output logic             fetchEn,
    output logic [addrW-1:0] fetchAddr,
    output logic             decEn,
    output fetchOut_t        decOut
);

    logic [addrW-1:0] pc;

    // no lookup for the old pc while redirecting
    assign fetchEn   = rdy_in && !jumpEn;
    assign fetchAddr = pc;

    // hit already carries rdy and jump
    assign decEn = hit && !stall;

    assign decOut.pc   = pc;
    assign decOut.inst = cacheInst;

    always_ff @(posedge clk_in) begin
        if (!rstN) begin
            pc <= '0;
        end else if (rdy_in) begin
            if (jumpEn) begin
                // a fill still in flight returns for the old pc
                pc <= jumpAddr;
            end else if (decEn) begin
                pc <= pc + addrW'(4);
            end
        end
    end

endmodule

/* hw/lsUnit.sv */
// load/store execution unit
`timescale 1ns/1ps

module lsUnit
    import cpuPkg::*;
(
    input  logic             clk_in,
    input  logic             rstN,
    input  logic             rdy_in,
    input  logic             lsWorkEn,
    input  lsCmd_t           lsCmd,
    output logic             lsBusy,
    output logic             dataEn,
    output memReq_t          dataReq,
    input  logic             dataDone,
    input  logic [dataW-1:0] ldData,
    output logic             lsDoneEn,
    output lsResult_t        lsResult
);

    logic busyQ;
    logic issueQ;
    logic doneQ;

    lsCmd_t    cmdQ;
    lsResult_t resultQ;

    logic [2:0]       len;
    logic             isStore;
    logic [dataW-1:0] extData;

    // size and direction from the opcode
    always_comb begin
        len     = 3'd4;
        isStore = 1'b0;
        case (cmdQ.op)
            LB, LBU: len = 3'd1;
            LH, LHU: len = 3'd2;
            SB: begin
                len     = 3'd1;
                isStore = 1'b1;
            end
            SH: begin
                len     = 3'd2;
                isStore = 1'b1;
            end
            SW: isStore = 1'b1;
            default: ;
        endcase
    end

    assign dataReq.addr  = cmdQ.base + cmdQ.imm;
    assign dataReq.len   = len;
    assign dataReq.write = isStore;
    assign dataReq.wdata = cmdQ.storeVal;

    // controller packs the bytes low
    always_comb begin
        case (cmdQ.op)
            LB:      extData = {{24{ldData[7]}}, ldData[7:0]};
            LH:      extData = {{16{ldData[15]}}, ldData[15:0]};
            LW:      extData = ldData;
            LBU:     extData = {24'd0, ldData[7:0]};
            LHU:     extData = {16'd0, ldData[15:0]};
            default: extData = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rstN) begin
            busyQ  <= 1'b0;
            issueQ <= 1'b0;
            doneQ  <= 1'b0;
        end else if (rdy_in) begin
            issueQ <= 1'b0;
            doneQ  <= 1'b0;
            if (!busyQ && lsWorkEn) begin
                busyQ  <= 1'b1;
                issueQ <= 1'b1;
            end else if (busyQ && dataDone) begin
                busyQ <= 1'b0;
                doneQ <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (!busyQ && lsWorkEn) begin
                cmdQ <= lsCmd;
            end
            if (busyQ && dataDone) begin
                resultQ.tag  <= cmdQ.tag;
                resultQ.data <= extData;
            end
        end
    end

    assign lsBusy   = busyQ;
    assign dataEn   = issueQ && rdy_in;
    assign lsDoneEn = doneQ && rdy_in;
    assign lsResult = resultQ;

endmodule

/* hw/memTop.sv */
// memory side of the core
`timescale 1ns/1ps

module cpuTop
    import cpuPkg::*;
#(
    parameter int icacheLines = 64
) (
    input  logic             clk_in,
    input  logic             rstN,
    input  logic             rdy_in,
    input  logic [7:0]       memDin,
    output logic [7:0]       memDout,
    output logic [addrW-1:0] memA,
    output logic             memWr,
    input  logic             jumpEn,
    input  logic [addrW-1:0] jumpAddr,
    input  logic             stall,
    output logic             decEn,
    output fetchOut_t        decOut,
    input  logic             lsWorkEn,
    input  lsCmd_t           lsCmd,
    output logic             lsBusy,
    output logic             lsDoneEn,
    output lsResult_t        lsResult
);

    logic             fetchEn;
    logic [addrW-1:0] fetchAddr;
    logic             hit;
    logic [dataW-1:0] cacheInst;
    logic             memFetchEn;
    logic [addrW-1:0] memFetchAddr;
    logic             instOutEn;
    logic [dataW-1:0] inst;
    logic [addrW-1:0] instAddr;
    logic             dataEn;
    memReq_t          dataReq;
    logic             dataDone;
    logic [dataW-1:0] ldData;

    fetch fetcher (
        .clk_in    (clk_in),
        .rstN      (rstN),
        .rdy_in    (rdy_in),
        .stall     (stall),
        .jumpEn    (jumpEn),
        .jumpAddr  (jumpAddr),
        .hit       (hit),
        .cacheInst (cacheInst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .decEn     (decEn),
        .decOut    (decOut)
    );

    icache #(
        .icacheLines (icacheLines)
    ) icache (
        .clk_in       (clk_in),
        .rstN         (rstN),
        .rdy_in       (rdy_in),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .instOutEn    (instOutEn),
        .inst         (inst),
        .instAddr     (instAddr),
        .hit          (hit),
        .cacheInst    (cacheInst),
        .memFetchEn   (memFetchEn),
        .memFetchAddr (memFetchAddr)
    );

    memCtrl mcu (
        .clk_in       (clk_in),
        .rstN         (rstN),
        .rdy_in       (rdy_in),
        .memFetchEn   (memFetchEn),
        .memFetchAddr (memFetchAddr),
        .instOutEn    (instOutEn),
        .inst         (inst),
        .instAddr     (instAddr),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .ldData       (ldData),
        .memDin       (memDin),
        .memDout      (memDout),
        .memA         (memA),
        .memWr        (memWr)
    );

    lsUnit ls (
        .clk_in   (clk_in),
        .rstN     (rstN),
        .rdy_in   (rdy_in),
        .lsWorkEn (lsWorkEn),
        .lsCmd    (lsCmd),
        .lsBusy   (lsBusy),
        .dataEn   (dataEn),
        .dataReq  (dataReq),
        .dataDone (dataDone),
        .ldData   (ldData),
        .lsDoneEn (lsDoneEn),
        .lsResult (lsResult)
    );

endmodule

/* test/ramModel.sv */
// byte RAM model for simulation
`timescale 1ns/1ps

module ramModel #(
    parameter int addrBits = 17
) (
    input  logic        clk_in,
    input  logic        en,
    input  logic [31:0] addr,
    input  logic [7:0]  wrData,
    input  logic        wr,
    output logic [7:0]  rdData
);

    logic [7:0]          mem [1 << addrBits];
    logic [addrBits-1:0] a;
    logic [7:0]          rdQ = 8'h00;

    assign a      = addr[addrBits-1:0];
    assign rdData = rdQ;

    // background pattern mixes all address bits
    initial begin
        for (int i = 0; i < (1 << addrBits); i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16) ^ 8'h5a);
        end
    end

    // read and write both freeze while the bus is paused
    always @(posedge clk_in) begin
        if (en) begin
            rdQ <= mem[a];
            if (wr) begin
                mem[a] = wrData;
            end
        end
    end

    // backdoor access
    function automatic logic [7:0] peekByte(input logic [31:0] ad);
        return mem[ad[addrBits-1:0]];
    endfunction

    task automatic pokeByte(input logic [31:0] ad, input logic [7:0] d);
        mem[ad[addrBits-1:0]] = d;
    endtask

endmodule

/* test/tbMemTop.sv */
// testbench for the memory side
`timescale 1ns/1ps

module tbMemTop import cpuPkg::*; ();

    localparam logic [31:0] seed      = 32'h6901;
    localparam int          progWords = 64;
    localparam int          waitLimit = 200;
    // cycle budgets per test
    localparam int budgetReset = 40;
    localparam int budgetSeq   = 9 * 40;
    localparam int budgetJump  = 4 * 60;
    localparam int budgetLs    = 24 * 40;
    localparam int budgetPause = 32 * 120;
    localparam int margin      = 500;
    localparam int budgetAll   = budgetReset + budgetSeq + budgetJump + budgetLs + budgetPause;

    logic             clk_in;
    logic             rstN;
    logic             rdy_in;
    logic [7:0]       memDin;
    logic [7:0]       memDout;
    logic [addrW-1:0] memA;
    logic             memWr;
    logic             jumpEn;
    logic [addrW-1:0] jumpAddr;
    logic             stall;
    logic             decEn;
    fetchOut_t        decOut;
    logic             lsWorkEn;
    lsCmd_t           lsCmd;
    logic             lsBusy;
    logic             lsDoneEn;
    lsResult_t        lsResult;

    int          checkCount;
    int          errorCount;
    logic [31:0] rngState;
    logic [31:0] nextPc;
    logic        pauseOn;
    logic [31:0] prog [progWords];

    cpuTop #(.icacheLines(64)) UUT (
        .clk_in(clk_in), .rstN(rstN), .rdy_in(rdy_in),
        .memDin(memDin), .memDout(memDout), .memA(memA), .memWr(memWr),
        .jumpEn(jumpEn), .jumpAddr(jumpAddr), .stall(stall),
        .decEn(decEn), .decOut(decOut),
        .lsWorkEn(lsWorkEn), .lsCmd(lsCmd), .lsBusy(lsBusy),
        .lsDoneEn(lsDoneEn), .lsResult(lsResult)
    );

    ramModel ram (
        .clk_in(clk_in), .en(rdy_in), .addr(memA),
        .wrData(memDout), .wr(memWr), .rdData(memDin)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // random rdy_in stretches from a separate generator state
    initial begin
        int          left;
        logic [31:0] st;
        left   = 0;
        st     = ~seed;
        rdy_in = 1'b1;
        forever begin
            @(negedge clk_in);
            if (!pauseOn) begin
                rdy_in = 1'b1;
            end else if (left > 0) begin
                left--;
                rdy_in = 1'b0;
            end else begin
                st = xorshift32(st);
                rdy_in = (st[1:0] != 2'b00);
                left = rdy_in ? 0 : int'(st[4:2]);
            end
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkPaused();
        if (!rdy_in) begin
            compareValue("decEn", 32'(decEn), 0);
            compareValue("lsDoneEn", 32'(lsDoneEn), 0);
            compareValue("memWr", 32'(memWr), 0);
        end
    endtask

    function automatic int sizeOf(input lsOp_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // RV32I load result from the raw little-endian bytes
    function automatic logic [31:0] extendLoad(input lsOp_e op, input logic [31:0] raw);
        logic [31:0] mask;
        logic        neg;
        mask = (sizeOf(op) == 4) ? 32'hffff_ffff : (32'h1 << (8 * sizeOf(op))) - 1;
        neg  = (op == LB || op == LH) && raw[8 * sizeOf(op) - 1];
        return neg ? (raw | ~mask) : (raw & mask);
    endfunction

    function automatic logic [31:0] ramWord(input logic [31:0] a);
        return {ram.peekByte(a + 3), ram.peekByte(a + 2), ram.peekByte(a + 1), ram.peekByte(a)};
    endfunction

    task automatic preloadProgram();
        logic [31:0] w;
        for (int i = 0; i < progWords; i++) begin
            w = nextRand();
            prog[i] = w;
            for (int b = 0; b < 4; b++) begin
                ram.pokeByte(32'(i * 4 + b), w[b*8 +: 8]);
            end
        end
    endtask

    // tasks below start and end on a falling edge
    task automatic expectFetch(input logic [31:0] pc, input logic [31:0] word);
        int   n;
        logic seen;
        n     = 0;
        seen  = 1'b0;
        stall = 1'b0;
        while (!seen && n < waitLimit) begin
            @(posedge clk_in);
            checkPaused();
            n++;
            if (decEn) begin
                seen = 1'b1;
                compareValue("decOut.pc", decOut.pc, pc);
                compareValue("decOut.inst", decOut.inst, word);
            end
        end
        if (!seen) begin
            errorCount++;
            $display("no decEn pulse within %0d cycles for pc 0x%08h", waitLimit, pc);
        end
        @(negedge clk_in);
        stall  = 1'b1;
        nextPc = pc + 4;
    endtask

    task automatic quietCycles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_in);
            compareValue("decEn", 32'(decEn), 0);
        end
        @(negedge clk_in);
    endtask

    task automatic jumpTo(input logic [31:0] target);
        jumpEn   = 1'b1;
        jumpAddr = target;
        nextPc   = target;
        @(negedge clk_in);
        jumpEn = 1'b0;
    endtask

    task automatic runLs(input lsOp_e op, input logic [31:0] base, input logic [31:0] imm,
                         input logic [31:0] value, input logic [3:0] tag,
                         output logic [31:0] data);
        int   n;
        logic accepted;
        logic seen;
        lsCmd.op       = op;
        lsCmd.base     = base;
        lsCmd.storeVal = value;
        lsCmd.imm      = imm;
        lsCmd.tag      = tag;
        lsWorkEn       = 1'b1;
        accepted       = 1'b0;
        // held until an edge with rdy_in high takes it
        while (!accepted) begin
            @(posedge clk_in);
            checkPaused();
            accepted = rdy_in;
        end
        @(negedge clk_in);
        lsWorkEn = 1'b0;
        compareValue("lsBusy", 32'(lsBusy), 1);
        n    = 0;
        seen = 1'b0;
        data = '0;
        while (!seen && n < waitLimit) begin
            @(posedge clk_in);
            checkPaused();
            n++;
            if (lsDoneEn) begin
                seen = 1'b1;
                compareValue("lsBusy", 32'(lsBusy), 0);
                compareValue("lsResult.tag", 32'(lsResult.tag), 32'(tag));
                data = lsResult.data;
            end
        end
        if (!seen) begin
            errorCount++;
            $display("no lsDoneEn pulse within %0d cycles for op %s", waitLimit, op.name());
        end
        @(negedge clk_in);
    endtask

    // random signed offset aligned to the access size
    function automatic logic [31:0] randImm(input int len);
        logic [31:0] r;
        r = nextRand();
        return {{26{r[5]}}, r[5:0]} & ~32'(len - 1);
    endfunction

    task automatic storeAndCheck(input lsOp_e op, input logic [31:0] addr);
        logic [31:0] value;
        logic [31:0] imm;
        logic [31:0] data;
        logic [7:0]  after;
        int          len;
        len   = sizeOf(op);
        value = nextRand();
        imm   = randImm(len);
        after = ram.peekByte(addr + 32'(len));
        runLs(op, addr - imm, imm, value, 4'(nextRand()), data);
        compareValue("lsResult.data", data, 0);
        for (int b = 0; b < len; b++) begin
            compareValue($sformatf("ram[%08h]", addr + 32'(b)),
                         32'(ram.peekByte(addr + 32'(b))), 32'(value[b*8 +: 8]));
        end
        compareValue($sformatf("ram[%08h]", addr + 32'(len)),
                     32'(ram.peekByte(addr + 32'(len))), 32'(after));
    endtask

    task automatic loadAndCheck(input lsOp_e op, input logic [31:0] addr);
        logic [31:0] imm;
        logic [31:0] exp;
        logic [31:0] data;
        imm = randImm(sizeOf(op));
        exp = extendLoad(op, ramWord(addr));
        runLs(op, addr - imm, imm, nextRand(), 4'(nextRand()), data);
        compareValue("lsResult.data", data, exp);
    endtask

    task automatic resetOutputs();
        compareValue("decEn", 32'(decEn), 0);
        compareValue("lsDoneEn", 32'(lsDoneEn), 0);
        compareValue("lsBusy", 32'(lsBusy), 0);
        compareValue("memWr", 32'(memWr), 0);
        rstN = 1'b1;
        expectFetch(32'h0, prog[0]);
    endtask

    task automatic fetchSequence();
        for (int i = 1; i <= 8; i++) begin
            expectFetch(nextPc, prog[nextPc[7:2]]);
            if (i % 3 == 0) begin
                quietCycles(8);
            end
        end
    endtask

    task automatic jumpRefetch();
        logic [31:0] target;
        target = 32'((16 + nextRand() % 32) * 4);
        jumpTo(target);
        expectFetch(target, prog[target[7:2]]);
        // RAM changes under a cached line
        storeAndCheck(SW, 32'h4);
        jumpTo(32'h4);
        expectFetch(32'h4, prog[1]);
    endtask

    task automatic storeLoadRounds(input int rounds);
        logic [31:0] a;
        for (int r = 0; r < rounds; r++) begin
            a = 32'h1000 + (nextRand() & 32'h0ff8);
            storeAndCheck(SW, a);
            storeAndCheck(SH, a + 4 + (nextRand() & 2));
            storeAndCheck(SB, a + (nextRand() & 3));
            loadAndCheck(LW, a);
            loadAndCheck(LH, a + (nextRand() & 6));
            loadAndCheck(LHU, a + (nextRand() & 6));
            loadAndCheck(LB, a + (nextRand() & 7));
            loadAndCheck(LBU, a + (nextRand() & 7));
        end
    endtask

    task automatic pausedTraffic();
        jumpTo(32'd192);
        @(posedge clk_in);
        pauseOn = 1'b1;
        @(negedge clk_in);
        for (int i = 0; i < 16; i++) begin
            expectFetch(nextPc, prog[nextPc[7:2]]);
        end
        storeLoadRounds(2);
        @(posedge clk_in);
        pauseOn = 1'b0;
        @(negedge clk_in);
    endtask

    task automatic finishRun(input logic timedOut);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        #((budgetAll + margin) * 10);
        $display("watchdog expired after %0d cycles, run did not complete", budgetAll + margin);
        finishRun(1'b1);
    end

    initial begin
        rstN       = 1'b0;
        jumpEn     = 1'b0;
        jumpAddr   = '0;
        stall      = 1'b0;
        lsWorkEn   = 1'b0;
        lsCmd      = '0;
        pauseOn    = 1'b0;
        checkCount = 0;
        errorCount = 0;
        rngState   = seed;
        nextPc     = '0;
        @(negedge clk_in);
        preloadProgram();
        repeat (3) @(negedge clk_in);
        resetOutputs();
        fetchSequence();
        jumpRefetch();
        storeLoadRounds(3);
        pausedTraffic();
        finishRun(1'b0);
    end

endmodule

/* src.f */
hw/cpuPkg.sv
hw/icache.sv
hw/memCtrl.sv
hw/fetch.sv
hw/lsUnit.sv
hw/memTop.sv
test/ramModel.sv
test/tbMemTop.sv

/* run.sh */
#!/bin/sh
# build and run the memory side testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tbMemTop -o simMemTop

out=$(./obj_dir/simMemTop)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -q -F '*** TEST PASSED ***'
